//--- source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int xlen       = 64;
    localparam int ilen       = 32;
    localparam int reg_addr_w = 5;

    // instruction field positions
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int funct7_lsb = 25;

    typedef enum logic [6:0] {
        opc_op        = 7'b0110011,
        opc_op_imm    = 7'b0010011,
        opc_op_32     = 7'b0111011,
        opc_op_imm_32 = 7'b0011011,
        opc_load      = 7'b0000011,
        opc_store     = 7'b0100011,
        opc_jal       = 7'b1101111,
        opc_jalr      = 7'b1100111,
        opc_lui       = 7'b0110111,
        opc_auipc     = 7'b0010111,
        opc_branch    = 7'b1100011,
        opc_system    = 7'b1110011
    } opcode_e;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sltiu   = 3'b011;
    localparam logic [2:0] f3_sri     = 3'b101;
    localparam logic [2:0] f3_lw      = 3'b010;
    localparam logic [2:0] f3_ld      = 3'b011;
    localparam logic [2:0] f3_lbu     = 3'b100;
    localparam logic [2:0] f3_sh      = 3'b001;
    localparam logic [2:0] f3_sd      = 3'b011;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    localparam logic [6:0]  funct7_sub  = 7'b0100000;   // sub, sra
    localparam logic [31:0] ebreak_code = 32'h0010_0073;

endpackage

`default_nettype wire

//--- source/core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

    typedef enum logic [1:0] {alu_add, alu_sub, alu_sltu, alu_sra} alu_op_e;

    typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_sel_e;

    typedef enum logic [1:0] {src_reg, src_imm, src_pc_imm, src_pc_four} alu_src_e;

    typedef enum logic [2:0] {
        size_none, size_byte_u, size_half, size_word_s, size_dword
    } mem_size_e;

    typedef struct packed {
        logic                            valid;
        logic [rv_isa_pkg::xlen-1:0]     pc;
        logic [rv_isa_pkg::ilen-1:0]     inst;
    } issue_t;

    typedef struct packed {
        logic                               reg_wen;
        logic [rv_isa_pkg::reg_addr_w-1:0]  rd;
        logic [rv_isa_pkg::reg_addr_w-1:0]  rs1;
        logic [rv_isa_pkg::reg_addr_w-1:0]  rs2;
        imm_sel_e                           imm_sel;
        alu_op_e                            alu_op;
        alu_src_e                           alu_src;
        logic                               word_op;     // 32-bit result, sign-extended
        logic                               mem_read;
        logic                               mem_write;
        mem_size_e                          mem_size;
        logic                               branch;
        logic                               branch_ne;   // bne, else beq
        logic                               jump;
        logic                               jalr;
        logic                               illegal;
        logic                               ebreak;
    } ctrl_t;

    typedef struct packed {
        logic                            valid;
        logic [rv_isa_pkg::xlen-1:0]     pc;
        logic [rv_isa_pkg::xlen-1:0]     next_pc;
        logic [rv_isa_pkg::xlen-1:0]     result;      // alu value or memory address
        logic [rv_isa_pkg::xlen-1:0]     store_data;
        ctrl_t                           ctrl;
    } exec_t;

    typedef struct packed {
        logic [rv_isa_pkg::xlen-1:0]        pc;
        logic [rv_isa_pkg::xlen-1:0]        next_pc;
        logic [rv_isa_pkg::reg_addr_w-1:0]  rd;
        logic                               reg_wen;
        logic [rv_isa_pkg::xlen-1:0]        wdata;
        logic                               illegal;
        logic                               ebreak;
    } retire_t;

endpackage

`default_nettype wire

//--- source/inst_issue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_issue #(
    parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          inst_valid,
    input  logic [rv_isa_pkg::ilen-1:0]   inst,
    input  logic                          redirect_valid,
    input  logic [rv_isa_pkg::xlen-1:0]   redirect_pc,
    output core_ctrl_pkg::issue_t         issue
);

    logic [rv_isa_pkg::xlen-1:0] pc;
    logic                        busy;   // strobed, pc not yet moved

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= reset_pc;
            busy        <= 1'b0;
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= inst_valid;
            if (inst_valid) begin
                busy <= 1'b1;
            end else if (redirect_valid) begin
                busy <= 1'b0;
            end
            if (redirect_valid) begin
                pc <= redirect_pc;         // next_pc from execute
            end
        end
        if (inst_valid) begin
            issue.pc   <= pc;
            issue.inst <= inst;
        end
    end

    // a strobe may only come once the pc has moved past the last instruction
    a_strobe_spacing: assert property (@(posedge clk) disable iff (rst) inst_valid |-> !busy)
        else $error("instruction strobe while previous one in flight");

endmodule

`default_nettype wire

//--- source/ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl (
    input  logic [rv_isa_pkg::ilen-1:0] inst,
    output core_ctrl_pkg::ctrl_t        ctrl
);

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;

    assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[rv_isa_pkg::funct3_lsb +: 3];
    assign funct7 = inst[rv_isa_pkg::funct7_lsb +: 7];

    always_comb begin
        ctrl          = '0;
        ctrl.rd       = inst[rv_isa_pkg::rd_lsb +: rv_isa_pkg::reg_addr_w];
        ctrl.rs1      = inst[rv_isa_pkg::rs1_lsb +: rv_isa_pkg::reg_addr_w];
        ctrl.rs2      = inst[rv_isa_pkg::rs2_lsb +: rv_isa_pkg::reg_addr_w];
        ctrl.imm_sel  = core_ctrl_pkg::imm_i;
        ctrl.alu_op   = core_ctrl_pkg::alu_add;
        ctrl.alu_src  = core_ctrl_pkg::src_imm;
        ctrl.mem_size = core_ctrl_pkg::size_none;
        ctrl.illegal  = 1'b1;                        // cleared by known encodings
        case (opcode)
            rv_isa_pkg::opc_op: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = core_ctrl_pkg::src_reg;
                ctrl.illegal = funct3 != rv_isa_pkg::f3_add_sub
                               || (funct7 != '0 && funct7 != rv_isa_pkg::funct7_sub);
                if (funct7 == rv_isa_pkg::funct7_sub) begin
                    ctrl.alu_op = core_ctrl_pkg::alu_sub;
                end
            end
            rv_isa_pkg::opc_op_32: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = core_ctrl_pkg::src_reg;
                ctrl.word_op = 1'b1;
                ctrl.illegal = funct3 != rv_isa_pkg::f3_add_sub || funct7 != '0;   // addw only
            end
            rv_isa_pkg::opc_op_imm: begin
                ctrl.reg_wen = 1'b1;
                case (funct3)
                    rv_isa_pkg::f3_add_sub: begin
                        ctrl.illegal = 1'b0;
                    end
                    rv_isa_pkg::f3_sltiu: begin
                        ctrl.alu_op  = core_ctrl_pkg::alu_sltu;
                        ctrl.illegal = 1'b0;
                    end
                    rv_isa_pkg::f3_sri: begin
                        ctrl.alu_op  = core_ctrl_pkg::alu_sra;
                        ctrl.illegal = funct7[6:1] != rv_isa_pkg::funct7_sub[6:1];  // shamt[5] below
                    end
                    default: begin
                        ctrl.illegal = 1'b1;
                    end
                endcase
            end
            rv_isa_pkg::opc_op_imm_32: begin
                ctrl.reg_wen = 1'b1;
                ctrl.word_op = 1'b1;
                ctrl.illegal = funct3 != rv_isa_pkg::f3_add_sub;
            end
            rv_isa_pkg::opc_load: begin
                ctrl.reg_wen  = 1'b1;
                ctrl.mem_read = 1'b1;
                case (funct3)
                    rv_isa_pkg::f3_lw:  ctrl.mem_size = core_ctrl_pkg::size_word_s;
                    rv_isa_pkg::f3_ld:  ctrl.mem_size = core_ctrl_pkg::size_dword;
                    rv_isa_pkg::f3_lbu: ctrl.mem_size = core_ctrl_pkg::size_byte_u;
                    default:            ctrl.mem_size = core_ctrl_pkg::size_none;
                endcase
                ctrl.illegal = ctrl.mem_size == core_ctrl_pkg::size_none;
            end
            rv_isa_pkg::opc_store: begin
                ctrl.mem_write = 1'b1;                   // no register write
                ctrl.imm_sel   = core_ctrl_pkg::imm_s;
                case (funct3)
                    rv_isa_pkg::f3_sh: ctrl.mem_size = core_ctrl_pkg::size_half;
                    rv_isa_pkg::f3_sd: ctrl.mem_size = core_ctrl_pkg::size_dword;
                    default:           ctrl.mem_size = core_ctrl_pkg::size_none;
                endcase
                ctrl.illegal = ctrl.mem_size == core_ctrl_pkg::size_none;
            end
            rv_isa_pkg::opc_branch: begin
                ctrl.alu_src   = core_ctrl_pkg::src_reg;
                ctrl.imm_sel   = core_ctrl_pkg::imm_b;
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = funct3 == rv_isa_pkg::f3_bne;
                ctrl.illegal   = funct3 != rv_isa_pkg::f3_beq && funct3 != rv_isa_pkg::f3_bne;
            end
            rv_isa_pkg::opc_jal: begin
                ctrl.reg_wen = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.imm_sel = core_ctrl_pkg::imm_j;
                ctrl.alu_src = core_ctrl_pkg::src_pc_four;   // link value
                ctrl.illegal = 1'b0;
            end
            rv_isa_pkg::opc_jalr: begin
                ctrl.reg_wen = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.alu_src = core_ctrl_pkg::src_pc_four;
                ctrl.illegal = funct3 != 3'b000;
            end
            rv_isa_pkg::opc_lui: begin
                ctrl.reg_wen = 1'b1;
                ctrl.rs1     = '0;                       // x0 + imm
                ctrl.imm_sel = core_ctrl_pkg::imm_u;
                ctrl.illegal = 1'b0;
            end
            rv_isa_pkg::opc_auipc: begin
                ctrl.reg_wen = 1'b1;
                ctrl.imm_sel = core_ctrl_pkg::imm_u;
                ctrl.alu_src = core_ctrl_pkg::src_pc_imm;
                ctrl.illegal = 1'b0;
            end
            rv_isa_pkg::opc_system: begin
                ctrl.ebreak  = inst == rv_isa_pkg::ebreak_code;
                ctrl.illegal = !ctrl.ebreak;
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
        if (ctrl.illegal) begin                          // retire as a no-op
            ctrl.reg_wen   = 1'b0;
            ctrl.mem_read  = 1'b0;
            ctrl.mem_write = 1'b0;
            ctrl.branch    = 1'b0;
            ctrl.jump      = 1'b0;
            ctrl.jalr      = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  logic [rv_isa_pkg::ilen-1:0]  inst,
    input  core_ctrl_pkg::imm_sel_e      imm_sel,
    output logic [rv_isa_pkg::xlen-1:0]  imm
);

    localparam int xlen = rv_isa_pkg::xlen;

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_sel)
            core_ctrl_pkg::imm_s: imm = {{(xlen-12){sign}}, inst[31:25], inst[11:7]};
            core_ctrl_pkg::imm_b: begin
                imm = {{(xlen-12){sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            core_ctrl_pkg::imm_u: imm = {{(xlen-32){sign}}, inst[31:12], 12'b0};
            core_ctrl_pkg::imm_j: begin
                imm = {{(xlen-20){sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default:              imm = {{(xlen-12){sign}}, inst[31:20]};   // i
        endcase
    end

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [rv_isa_pkg::reg_addr_w-1:0]   raddr1,
    input  logic [rv_isa_pkg::reg_addr_w-1:0]   raddr2,
    output logic [rv_isa_pkg::xlen-1:0]         rdata1,
    output logic [rv_isa_pkg::xlen-1:0]         rdata2,
    input  logic                                wen,
    input  logic [rv_isa_pkg::reg_addr_w-1:0]   waddr,
    input  logic [rv_isa_pkg::xlen-1:0]         wdata
);

    logic [rv_isa_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin   // x0 not writable
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];   // x0 reads its zero entry
    assign rdata2 = regs[raddr2];

    a_x0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
        else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

//--- source/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic                         clk,
    input  logic                         rst,
    input  core_ctrl_pkg::issue_t        issue,
    input  core_ctrl_pkg::ctrl_t         ctrl,
    input  logic [rv_isa_pkg::xlen-1:0]  imm,
    input  logic [rv_isa_pkg::xlen-1:0]  rs1_data,
    input  logic [rv_isa_pkg::xlen-1:0]  rs2_data,
    output core_ctrl_pkg::exec_t         exec,
    output logic                         redirect_valid,
    output logic [rv_isa_pkg::xlen-1:0]  redirect_pc
);

    localparam int xlen = rv_isa_pkg::xlen;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] result;
    logic [xlen-1:0] target_sum;
    logic [xlen-1:0] next_pc;
    logic            taken;

    always_comb begin
        case (ctrl.alu_src)
            core_ctrl_pkg::src_imm: begin
                op_a = rs1_data;
                op_b = imm;
            end
            core_ctrl_pkg::src_pc_imm: begin
                op_a = issue.pc;
                op_b = imm;
            end
            core_ctrl_pkg::src_pc_four: begin
                op_a = issue.pc;
                op_b = xlen'(4);
            end
            default: begin
                op_a = rs1_data;
                op_b = rs2_data;
            end
        endcase
        case (ctrl.alu_op)
            core_ctrl_pkg::alu_sub:  alu_out = op_a - op_b;
            core_ctrl_pkg::alu_sltu: alu_out = xlen'(op_a < op_b);
            core_ctrl_pkg::alu_sra:  alu_out = $signed(op_a) >>> op_b[5:0];
            default:                 alu_out = op_a + op_b;
        endcase
        result = ctrl.word_op ? {{(xlen-32){alu_out[31]}}, alu_out[31:0]} : alu_out;
    end

    assign taken      = ctrl.branch && ((rs1_data == rs2_data) != ctrl.branch_ne);
    assign target_sum = (ctrl.jalr ? rs1_data : issue.pc) + imm;
    // bit 0 only ever set by jalr
    assign next_pc    = (taken || ctrl.jump) ? {target_sum[xlen-1:1], 1'b0}
                                             : issue.pc + xlen'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            exec.valid <= 1'b0;
        end else begin
            exec.valid <= issue.valid;
        end
        if (issue.valid) begin
            exec.pc         <= issue.pc;
            exec.next_pc    <= next_pc;
            exec.result     <= result;
            exec.store_data <= rs2_data;
            exec.ctrl       <= ctrl;
        end
    end

    assign redirect_valid = exec.valid;
    assign redirect_pc    = exec.next_pc;

endmodule

`default_nettype wire

//--- source/mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb #(
    parameter int dmem_words = 512
) (
    input  logic                                clk,
    input  logic                                rst,
    input  core_ctrl_pkg::exec_t                exec,
    output logic                                wb_en,
    output logic [rv_isa_pkg::reg_addr_w-1:0]   wb_addr,
    output logic [rv_isa_pkg::xlen-1:0]         wb_data,
    output logic                                retire_valid,
    output core_ctrl_pkg::retire_t              retire
);

    localparam int xlen      = rv_isa_pkg::xlen;
    localparam int addr_bits = $clog2(dmem_words);

    logic [xlen-1:0]      dmem [dmem_words];
    logic [addr_bits-1:0] word_idx;
    logic [2:0]           byte_off;
    logic [xlen-1:0]      ld_word;
    logic [xlen-1:0]      load_data;

    assign word_idx = exec.result[3 +: addr_bits];
    assign byte_off = exec.result[2:0];
    assign ld_word  = dmem[word_idx] >> {byte_off, 3'b000};   // addressed byte to bit 0

    always_comb begin
        case (exec.ctrl.mem_size)
            core_ctrl_pkg::size_byte_u: load_data = {{(xlen-8){1'b0}}, ld_word[7:0]};
            core_ctrl_pkg::size_word_s: begin
                load_data = {{(xlen-32){ld_word[31]}}, ld_word[31:0]};
            end
            default:                    load_data = ld_word;     // ld
        endcase
    end

    assign wb_en   = exec.valid && exec.ctrl.reg_wen;
    assign wb_addr = exec.ctrl.rd;
    assign wb_data = exec.ctrl.mem_read ? load_data : exec.result;

    always_ff @(posedge clk) begin
        if (exec.valid && exec.ctrl.mem_write) begin
            if (exec.ctrl.mem_size == core_ctrl_pkg::size_dword) begin
                dmem[word_idx] <= exec.store_data;
            end else begin
                dmem[word_idx][{byte_off, 3'b000} +: 16] <= exec.store_data[15:0];  // sh
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= exec.valid;
        end
        if (exec.valid) begin
            retire.pc      <= exec.pc;
            retire.next_pc <= exec.next_pc;
            retire.rd      <= exec.ctrl.reg_wen ? exec.ctrl.rd : '0;
            retire.reg_wen <= exec.ctrl.reg_wen;
            retire.wdata   <= exec.ctrl.reg_wen ? wb_data : '0;
            retire.illegal <= exec.ctrl.illegal;
            retire.ebreak  <= exec.ctrl.ebreak;
        end
    end

    a_store_aligned: assert property (@(posedge clk) disable iff (rst)
        exec.valid && exec.ctrl.mem_write |->
            (exec.ctrl.mem_size == core_ctrl_pkg::size_half ? !byte_off[0] : byte_off == '0))
        else $error("misaligned store");

endmodule

`default_nettype wire

//--- source/rv64_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv64_core #(
    parameter logic [rv_isa_pkg::xlen-1:0] reset_pc   = '0,
    parameter int                          dmem_words = 512
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         inst_valid,
    input  logic [rv_isa_pkg::ilen-1:0]  inst,
    output logic                         retire_valid,
    output core_ctrl_pkg::retire_t       retire
);

    core_ctrl_pkg::issue_t                 issue;
    core_ctrl_pkg::ctrl_t                  dec;
    core_ctrl_pkg::exec_t                  exec;
    logic [rv_isa_pkg::xlen-1:0]           imm;
    logic [rv_isa_pkg::xlen-1:0]           rs1_data;
    logic [rv_isa_pkg::xlen-1:0]           rs2_data;
    logic                                  redirect_valid;
    logic [rv_isa_pkg::xlen-1:0]           redirect_pc;
    logic                                  wb_en;
    logic [rv_isa_pkg::reg_addr_w-1:0]     wb_addr;
    logic [rv_isa_pkg::xlen-1:0]           wb_data;

    inst_issue #(.reset_pc(reset_pc)) issue0 (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .issue          (issue)
    );

    ctrl ctrl0 (
        .inst (issue.inst),
        .ctrl (dec)
    );

    imm_gen imm0 (
        .inst    (issue.inst),
        .imm_sel (dec.imm_sel),
        .imm     (imm)
    );

    reg_file rf0 (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .wen    (wb_en),
        .waddr  (wb_addr),
        .wdata  (wb_data)
    );

    exec_unit ex0 (
        .clk            (clk),
        .rst            (rst),
        .issue          (issue),
        .ctrl           (dec),
        .imm            (imm),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .exec           (exec),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    mem_wb #(.dmem_words(dmem_words)) mw0 (
        .clk          (clk),
        .rst          (rst),
        .exec         (exec),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

//--- verif/tb_program.svh
`ifndef tb_program_svh
`define tb_program_svh
`default_nettype none

task automatic build_program();
    logic [63:0] rnd;
    logic [63:0] x1, x2, x3, x4, x5, x6, x10;
    logic [63:0] mem_a;                                 // dword at x5 + 8
    take_bits(12, rnd);
    x1 = sext12(rnd[11:0]);
    add_write(enc_i(rnd[11:0], 5'd0, 3'd0, 5'd1, op_imm), 5'd1, x1);
    take_bits(12, rnd);
    x2 = sext12(rnd[11:0]);
    add_write(enc_i(rnd[11:0], 5'd0, 3'd0, 5'd2, op_imm), 5'd2, x2);
    x3 = x1 + x2;
    add_write(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, op_reg), 5'd3, x3);
    x4 = x1 - x2;
    add_write(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd4, op_reg), 5'd4, x4);
    take_bits(12, rnd);
    add_write(enc_i(rnd[11:0], 5'd3, 3'd0, 5'd21, op_imm), 5'd21, x3 + sext12(rnd[11:0]));
    take_bits(12, rnd);
    add_write(enc_i(rnd[11:0], 5'd2, 3'd3, 5'd8, op_imm), 5'd8,
              64'(x2 < sext12(rnd[11:0])));         // unsigned compare
    x6 = 64'hffff_ffff_8000_0000;
    add_write(enc_u(20'h80000, 5'd6, op_lui), 5'd6, x6);
    add_write(enc_i(12'h424, 5'd6, 3'd5, 5'd7, op_imm), 5'd7, 64'($signed(x6) >>> 36));
    add_write(enc_u(20'h12345, 5'd9, op_auipc), 5'd9, pc_model + 64'h1234_5000);
    add_write(enc_u(20'h80000, 5'd10, op_lui), 5'd10, 64'hffff_ffff_8000_0000);
    x10 = 64'hffff_ffff_8000_0000 + sext12(12'hfff);
    add_write(enc_i(12'hfff, 5'd10, 3'd0, 5'd10, op_imm), 5'd10, x10);
    add_write(enc_r(7'h00, 5'd10, 5'd10, 3'd0, 5'd11, op_32), 5'd11,
              sext32(x10[31:0] + x10[31:0]));       // wraps past bit 31
    add_write(enc_i(12'h001, 5'd10, 3'd0, 5'd12, op_imm_32), 5'd12,
              sext32(x10[31:0] + 32'd1));
    x5 = 64'h100;
    add_write(enc_i(12'h100, 5'd0, 3'd0, 5'd5, op_imm), 5'd5, x5);
    add_quiet(enc_s(12'd8, 5'd3, 5'd5, 3'd3), pc_model + 64'd4);
    mem_a = x3;
    add_write(enc_i(12'd8, 5'd5, 3'd3, 5'd13, op_load), 5'd13, mem_a);
    add_quiet(enc_s(12'd10, 5'd4, 5'd5, 3'd1), pc_model + 64'd4);
    mem_a[31:16] = x4[15:0];                            // sh touches two bytes only
    add_write(enc_i(12'd8, 5'd5, 3'd3, 5'd14, op_load), 5'd14, mem_a);
    add_write(enc_i(12'd8, 5'd5, 3'd2, 5'd15, op_load), 5'd15, sext32(mem_a[31:0]));
    add_quiet(enc_s(12'd16, 5'd6, 5'd5, 3'd3), pc_model + 64'd4);
    add_write(enc_i(12'd16, 5'd5, 3'd2, 5'd16, op_load), 5'd16, sext32(x6[31:0]));
    add_write(enc_i(12'd20, 5'd5, 3'd4, 5'd17, op_load), 5'd17, {56'd0, x6[39:32]});
    add_quiet(enc_b(13'd16, 5'd1, 5'd1, 3'd0), pc_model + 64'd16);
    add_quiet(enc_b(13'd16, 5'd1, 5'd1, 3'd1), pc_model + 64'd4);
    add_quiet(enc_b(13'h1ff8, 5'd2, 5'd1, 3'd1),
              (x1 != x2) ? pc_model - 64'd8 : pc_model + 64'd4);
    add_quiet(enc_b(13'd12, 5'd2, 5'd1, 3'd0),
              (x1 == x2) ? pc_model + 64'd12 : pc_model + 64'd4);
    add_row(enc_j(21'd2048, 5'd18), 5'd18, 1'b1, pc_model + 64'd4, pc_model + 64'd2048,
            1'b0, 1'b0);
    add_row(enc_i(12'h021, 5'd5, 3'd0, 5'd19, op_jalr), 5'd19, 1'b1, pc_model + 64'd4,
            (x5 + 64'h21) & ~64'd1, 1'b0, 1'b0);
    add_row(32'hffff_ffff, 5'd0, 1'b0, 64'd0, pc_model + 64'd4, 1'b1, 1'b0);
    add_row(32'h0000_0073, 5'd0, 1'b0, 64'd0, pc_model + 64'd4, 1'b1, 1'b0);   // ecall
    add_row(32'h0010_0073, 5'd0, 1'b0, 64'd0, pc_model + 64'd4, 1'b0, 1'b1);
    add_write(enc_i(12'h005, 5'd1, 3'd0, 5'd0, op_imm), 5'd0, x1 + 64'd5);
    add_write(enc_r(7'h00, 5'd2, 5'd0, 3'd0, 5'd20, op_reg), 5'd20, x2);      // x0 still zero
endtask

`default_nettype wire
`endif

//--- verif/tb_rv64_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv64_core;

    localparam logic [63:0] start_pc     = 64'h0000_0000_0000_1000;
    localparam int          dmem_words   = 512;
    localparam int          reset_cycles = 5;

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_32     = 7'b0111011;
    localparam logic [6:0] op_imm_32 = 7'b0011011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    typedef struct packed {
        logic [31:0]            inst;
        core_ctrl_pkg::retire_t exp;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic                   inst_valid;
    logic [31:0]            inst;
    logic                   retire_valid;
    core_ctrl_pkg::retire_t retire;

    row_t        rows[$];
    logic [63:0] pc_model;     // pc of the next row
    logic [31:0] lfsr_state;
    int          cycles;
    int          cycle_limit;

    rv64_core #(.reset_pc(start_pc), .dmem_words(dmem_words)) dut0 (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Checks failed");
            $fatal(1, "timeout: no retire within %0d cycles", cycle_limit);
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[62:0], lfsr_state[31]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [63:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic add_row(input logic [31:0] code, input logic [4:0] rd, input logic wen,
                           input logic [63:0] wdata, input logic [63:0] next_pc,
                           input logic illegal, input logic ebreak);
        row_t r;
        r.inst        = code;
        r.exp.pc      = pc_model;
        r.exp.next_pc = next_pc;
        r.exp.rd      = rd;
        r.exp.reg_wen = wen;
        r.exp.wdata   = wdata;
        r.exp.illegal = illegal;
        r.exp.ebreak  = ebreak;
        rows.push_back(r);
        pc_model = next_pc;
    endtask

    task automatic add_write(input logic [31:0] code, input logic [4:0] rd,
                             input logic [63:0] value);
        add_row(code, rd, 1'b1, value, pc_model + 64'd4, 1'b0, 1'b0);
    endtask

    task automatic add_quiet(input logic [31:0] code, input logic [63:0] next_pc);
        add_row(code, 5'd0, 1'b0, 64'd0, next_pc, 1'b0, 1'b0);
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "retire record mismatch");
        end
    endtask

    task automatic run_row(input row_t r);
        inst_valid = 1'b1;
        inst       = r.inst;
        @(negedge clk);
        inst_valid = 1'b0;
        while (!retire_valid) begin
            @(negedge clk);
        end
        check_value("pc", retire.pc, r.exp.pc);
        check_value("next_pc", retire.next_pc, r.exp.next_pc);
        check_value("rd", 64'(retire.rd), 64'(r.exp.rd));
        check_value("reg_wen", 64'(retire.reg_wen), 64'(r.exp.reg_wen));
        check_value("wdata", retire.wdata, r.exp.wdata);
        check_value("illegal", 64'(retire.illegal), 64'(r.exp.illegal));
        check_value("ebreak", 64'(retire.ebreak), 64'(r.exp.ebreak));
        @(negedge clk);
        check_value("retire_valid one cycle", 64'(retire_valid), 64'd0);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        inst_valid  = 1'b0;
        inst        = '0;
        cycles      = 0;
        cycle_limit = 0;
        lfsr_state  = 32'h48c2_d975;
        pc_model    = start_pc;
        build_program();
        cycle_limit = rows.size() * 6 + 40;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        check_value("retire_valid after reset", 64'(retire_valid), 64'd0);
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("All checks passed");
        $finish;
    end

`include "tb_program.svh"

endmodule

`default_nettype wire

//--- project.f
+incdir+verif
source/rv_isa_pkg.sv
source/core_ctrl_pkg.sv
source/inst_issue.sv
source/ctrl.sv
source/imm_gen.sv
source/reg_file.sv
source/exec_unit.sv
source/mem_wb.sv
source/rv64_core.sv
verif/tb_rv64_core.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module tb_rv64_core -Mdir obj_dir \
    && ./obj_dir/Vtb_rv64_core \
    || exit 1
